//--- dv/tb_ex_top.sv
`timescale 1ns/100ps
module tb_ex_top;

	localparam int N_ALU  = 200;
	localparam int N_SFT  = 100;
	localparam int N_BR   = 60;
	localparam int N_MUL  = 12;
	localparam int N_DIV  = 12;
	localparam int N_MOVE = 8;
	// Long ops count an issue, the wait and two reads
	localparam int N_OPS  = N_ALU + N_SFT + N_BR + 4 * N_MUL + 4 * N_DIV + 5 * N_MOVE + 30;
	localparam int LIMIT  = N_OPS * (cpu_pkg::DIV_CYCLES + 4) + 100;

	logic                 clk = 1'b0;
	logic                 arst_n;
	logic                 in_valid;
	cpu_pkg::word_t       pc;
	cpu_pkg::imm_t        imm;
	cpu_pkg::shamt_t      sa;
	cpu_pkg::reg_addr_t   rs;
	cpu_pkg::reg_addr_t   rt;
	cpu_pkg::reg_addr_t   rd;
	cpu_pkg::word_t       rsdata;
	cpu_pkg::word_t       rtdata;
	cpu_pkg::alu_func_t   alu_func;
	cpu_pkg::sft_func_t   sft_func;
	logic                 imm_sign;
	logic                 alu_srcb_rt;
	logic                 sft_srca_imm;
	logic                 sft_srcb_rs;
	cpu_pkg::out_sel_t    out_sel;
	cpu_pkg::regdst_t     regdst;
	logic                 regwrite;
	logic                 intovf_en;
	logic                 hi_wen;
	logic                 lo_wen;
	cpu_pkg::hilo_src_t   hi_src;
	cpu_pkg::hilo_src_t   lo_src;
	logic                 mul_en;
	logic                 mul_sign;
	logic                 div_en;
	logic                 div_sign;
	logic                 br_equal;
	logic                 br_gtz;
	logic                 br_eqz;
	cpu_pkg::word_t       bta;
	cpu_pkg::word_t       bpc;
	logic                 busy;
	logic                 mem_valid;
	cpu_pkg::word_t       mem_pc;
	cpu_pkg::word_t       mem_result;
	cpu_pkg::reg_addr_t   mem_reg_waddr;
	logic                 mem_regwrite;
	logic                 mem_intovf;

	logic [31:0]          seed;
	int                   n_checks = 0;
	int                   n_errors = 0;
	int                   errs_before = 0;
	int                   cycles = 0;

	// Model state kept by the comparing process
	logic                 pend_en;
	logic                 pend_valid;
	cpu_pkg::word_t       pend_pc;
	cpu_pkg::word_t       pend_result;
	cpu_pkg::reg_addr_t   pend_waddr;
	logic                 pend_regwrite;
	logic                 pend_intovf;
	int                   busy_left;
	cpu_pkg::word_t       shadow_hi;
	cpu_pkg::word_t       shadow_lo;
	logic [63:0]          prod;
	cpu_pkg::word_t       quo;
	cpu_pkg::word_t       rem;

	ex_top uut (.*);

	always #5 clk = ~clk;

	function automatic logic [31:0] next_random();
		logic [15:0] upper;
		seed  = seed * 32'd1664525 + 32'd1013904223;
		upper = seed[31:16];
		seed  = seed * 32'd1664525 + 32'd1013904223;
		return {upper, seed[31:16]};
	endfunction

	function automatic cpu_pkg::word_t alu_ref(input cpu_pkg::alu_func_t f,
			input cpu_pkg::word_t a, input cpu_pkg::word_t b, output logic ovf);
		logic [32:0] wide;
		ovf = 1'b0;
		case (f)
			cpu_pkg::ADD, cpu_pkg::ADDU: begin
				wide = {a[31], a} + {b[31], b};
				ovf  = (f == cpu_pkg::ADD) && (wide[32] != wide[31]);
				return wide[31:0];
			end
			cpu_pkg::SUB, cpu_pkg::SUBU: begin
				wide = {a[31], a} - {b[31], b};
				ovf  = (f == cpu_pkg::SUB) && (wide[32] != wide[31]);
				return wide[31:0];
			end
			cpu_pkg::AND:  return a & b;
			cpu_pkg::OR:   return a | b;
			cpu_pkg::XOR:  return a ^ b;
			cpu_pkg::NOR:  return ~(a | b);
			cpu_pkg::SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			cpu_pkg::SLTU: return (a < b) ? 32'd1 : 32'd0;
			cpu_pkg::LUI:  return {b[15:0], 16'h0000};
			default:       return 32'd0;
		endcase
	endfunction

	function automatic cpu_pkg::word_t shift_ref(input cpu_pkg::sft_func_t f,
			input cpu_pkg::word_t v, input cpu_pkg::shamt_t n);
		case (f)
			cpu_pkg::SLL: return v << n;
			cpu_pkg::SRL: return v >> n;
			// Vacated bits copy the sign
			cpu_pkg::SRA: return v[31] ? ((v >> n) | ~(32'hffff_ffff >> n)) : (v >> n);
			default:      return 32'd0;
		endcase
	endfunction

	function automatic void div_ref(input logic sgn, input cpu_pkg::word_t a,
			input cpu_pkg::word_t b, output cpu_pkg::word_t q, output cpu_pkg::word_t r);
		cpu_pkg::word_t ma;
		cpu_pkg::word_t mb;
		ma = (sgn && a[31]) ? -a : a;
		mb = (sgn && b[31]) ? -b : b;
		if (mb == 32'd0) begin
			q = 32'hffff_ffff;
			r = ma;
		end else begin
			q = ma / mb;
			r = ma % mb;
		end
		if (sgn && (a[31] ^ b[31])) begin
			q = -q;
		end
		if (sgn && a[31]) begin
			r = -r;
		end
	endfunction

	// Expected EX/MEM contents for the fields on the inputs now
	function automatic void expect_ex(output cpu_pkg::word_t res,
			output cpu_pkg::reg_addr_t waddr, output logic wr, output logic ovf);
		cpu_pkg::word_t  imm_ext;
		cpu_pkg::word_t  alu_out;
		logic            alu_ovf;
		cpu_pkg::word_t  sft_in;
		cpu_pkg::shamt_t amount;
		imm_ext = imm_sign ? {{16{imm[15]}}, imm} : {16'h0000, imm};
		alu_out = alu_ref(alu_func, rsdata, alu_srcb_rt ? rtdata : imm_ext, alu_ovf);
		sft_in  = sft_srca_imm ? imm_ext : rtdata;
		amount  = sft_srcb_rs ? rsdata[4:0] : sa;
		case (out_sel)
			cpu_pkg::OUT_SFT:  res = shift_ref(sft_func, sft_in, amount);
			cpu_pkg::OUT_HI:   res = shadow_hi;
			cpu_pkg::OUT_LO:   res = shadow_lo;
			cpu_pkg::OUT_LINK: res = pc + 32'd8;
			default:           res = alu_out;
		endcase
		case (regdst)
			cpu_pkg::DST_RD: waddr = rd;
			cpu_pkg::DST_RA: waddr = 5'd31;
			default:         waddr = rt;
		endcase
		ovf = intovf_en && alu_ovf;
		wr  = regwrite && !ovf;
	endfunction

	task automatic compare_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	// Compares mid-cycle where everything is settled
	always @(negedge clk) begin
		if (!arst_n) begin
			pend_en   = 1'b0;
			busy_left = 0;
			shadow_hi = 32'd0;
			shadow_lo = 32'd0;
		end else begin
			if (pend_en) begin
				compare_value("mem_valid", 32'(mem_valid), 32'(pend_valid));
				compare_value("mem_regwrite", 32'(mem_regwrite), 32'(pend_regwrite));
				compare_value("mem_intovf", 32'(mem_intovf), 32'(pend_intovf));
				if (pend_valid) begin
					compare_value("mem_pc", mem_pc, pend_pc);
					compare_value("mem_result", mem_result, pend_result);
					compare_value("mem_reg_waddr", 32'(mem_reg_waddr), 32'(pend_waddr));
				end
			end
			compare_value("busy", 32'(busy), 32'(busy_left != 0));
			compare_value("br_equal", 32'(br_equal), 32'(rsdata == rtdata));
			compare_value("br_eqz", 32'(br_eqz), 32'(rsdata == 32'd0));
			compare_value("br_gtz", 32'(br_gtz), 32'($signed(rsdata) > 32'sd0));
			compare_value("bta", bta, pc + 32'd4 + ({{16{imm[15]}}, imm} << 2));
			compare_value("bpc", bpc, pc + 32'd8);

			expect_ex(pend_result, pend_waddr, pend_regwrite, pend_intovf);
			pend_en    = 1'b1;
			pend_pc    = pc;
			pend_valid = in_valid && (busy_left == 0);
			if (!pend_valid) begin
				pend_regwrite = 1'b0;
				pend_intovf   = 1'b0;
			end
			if (busy_left > 0) begin
				busy_left--;
			end

			// HI/LO shadow follows the issue since reads wait for busy to drop
			if (in_valid && mul_en) begin
				prod = {{32{mul_sign & rsdata[31]}}, rsdata} *
					{{32{mul_sign & rtdata[31]}}, rtdata};
				if (hi_wen) shadow_hi = prod[63:32];
				if (lo_wen) shadow_lo = prod[31:0];
				busy_left = cpu_pkg::MUL_LATENCY;
			end else if (in_valid && div_en) begin
				div_ref(div_sign, rsdata, rtdata, quo, rem);
				if (hi_wen) shadow_hi = rem;
				if (lo_wen) shadow_lo = quo;
				busy_left = cpu_pkg::DIV_CYCLES + 1;
			end else if (in_valid) begin
				if (hi_wen && hi_src == cpu_pkg::SRC_RS) shadow_hi = rsdata;
				if (lo_wen && lo_src == cpu_pkg::SRC_RS) shadow_lo = rsdata;
			end
		end
	end

	task automatic drive_defaults();
		in_valid     <= 1'b0;
		pc           <= 32'd0;
		imm          <= 16'd0;
		sa           <= 5'd0;
		rs           <= 5'd0;
		rt           <= 5'd0;
		rd           <= 5'd0;
		rsdata       <= 32'd0;
		rtdata       <= 32'd0;
		alu_func     <= cpu_pkg::ADD;
		sft_func     <= cpu_pkg::SLL;
		imm_sign     <= 1'b0;
		alu_srcb_rt  <= 1'b0;
		sft_srca_imm <= 1'b0;
		sft_srcb_rs  <= 1'b0;
		out_sel      <= cpu_pkg::OUT_ALU;
		regdst       <= cpu_pkg::DST_RT;
		regwrite     <= 1'b0;
		intovf_en    <= 1'b0;
		hi_wen       <= 1'b0;
		lo_wen       <= 1'b0;
		hi_src       <= cpu_pkg::SRC_MUL;
		lo_src       <= cpu_pkg::SRC_MUL;
		mul_en       <= 1'b0;
		mul_sign     <= 1'b0;
		div_en       <= 1'b0;
		div_sign     <= 1'b0;
	endtask

	task automatic next_cycle();
		@(posedge clk);
		drive_defaults();
	endtask

	// Valid instruction with random fields and a nonzero rs
	task automatic random_fields();
		logic [31:0] r;
		r = next_random();
		pc       <= {r[31:2], 2'b00};
		r = next_random();
		imm      <= r[15:0];
		sa       <= r[20:16];
		rt       <= r[25:21];
		rd       <= r[30:26];
		r = next_random();
		rs       <= 5'(32'd1 + r % 32'd31);
		rsdata   <= next_random();
		rtdata   <= next_random();
		in_valid <= 1'b1;
	endtask

	task automatic alu_op();
		logic [31:0] r;
		random_fields();
		r = next_random();
		alu_func    <= cpu_pkg::alu_func_t'(4'(r % 32'd11));
		alu_srcb_rt <= r[8];
		imm_sign    <= r[9];
		intovf_en   <= r[10] | r[11];
		regdst      <= r[12] ? cpu_pkg::DST_RD : cpu_pkg::DST_RT;
		regwrite    <= 1'b1;
	endtask

	// Keep issuing plain ops until the DUT drops busy
	task automatic wait_not_busy();
		logic still;
		still = 1'b1;
		while (still) begin
			next_cycle();
			alu_op();
			@(negedge clk);
			still = busy;
		end
	endtask

	task automatic read_hilo();
		next_cycle();
		random_fields();
		out_sel  <= cpu_pkg::OUT_HI;
		regdst   <= cpu_pkg::DST_RD;
		regwrite <= 1'b1;
		next_cycle();
		random_fields();
		out_sel  <= cpu_pkg::OUT_LO;
		regdst   <= cpu_pkg::DST_RD;
		regwrite <= 1'b1;
	endtask

	task automatic long_op(input logic is_div, input logic sgn, input cpu_pkg::word_t a,
			input cpu_pkg::word_t b);
		next_cycle();
		random_fields();
		rsdata   <= a;
		rtdata   <= b;
		mul_en   <= !is_div;
		div_en   <= is_div;
		mul_sign <= sgn;
		div_sign <= sgn;
		hi_wen   <= 1'b1;
		lo_wen   <= 1'b1;
		hi_src   <= is_div ? cpu_pkg::SRC_DIV : cpu_pkg::SRC_MUL;
		lo_src   <= is_div ? cpu_pkg::SRC_DIV : cpu_pkg::SRC_MUL;
		wait_not_busy();
		read_hilo();
	endtask

	task automatic end_test(input string name);
		next_cycle();
		next_cycle();
		$display("test %s finished with %0d errors", name, n_errors - errs_before);
		errs_before = n_errors;
	endtask

	task automatic alu_test();
		for (int i = 0; i < N_ALU; i++) begin
			next_cycle();
			alu_op();
			// A few fixed overflow corners up front
			if (i < 4) begin
				alu_srcb_rt <= 1'b1;
				intovf_en   <= 1'b1;
				rtdata      <= 32'd1;
				case (i)
					0: alu_func <= cpu_pkg::ADD;
					1: alu_func <= cpu_pkg::ADDU;
					2: alu_func <= cpu_pkg::SUB;
					default: alu_func <= cpu_pkg::SUBU;
				endcase
				rsdata <= (i < 2) ? 32'h7fff_ffff : 32'h8000_0000;
			end
		end
		end_test("alu");
	endtask

	task automatic shift_test();
		logic [31:0] r;
		for (int i = 0; i < N_SFT; i++) begin
			next_cycle();
			random_fields();
			r = next_random();
			sft_func     <= cpu_pkg::sft_func_t'(2'(r % 32'd3));
			sft_srcb_rs  <= r[4];
			sft_srca_imm <= r[5];
			imm_sign     <= r[6];
			out_sel      <= cpu_pkg::OUT_SFT;
			regdst       <= cpu_pkg::DST_RD;
			regwrite     <= 1'b1;
		end
		end_test("shift");
	endtask

	task automatic branch_test();
		logic [31:0] r;
		logic [31:0] v;
		for (int i = 0; i < N_BR; i++) begin
			next_cycle();
			random_fields();
			r = next_random();
			v = next_random();
			case (r % 32'd5)
				0: begin
					rsdata <= v;
					rtdata <= v;
				end
				1: rsdata <= 32'd0;
				2: rsdata <= {1'b1, v[30:0]};
				3: rsdata <= 32'd1;
				default: ;
			endcase
			// Jump and link
			if (r[8]) begin
				out_sel  <= cpu_pkg::OUT_LINK;
				regdst   <= cpu_pkg::DST_RA;
				regwrite <= 1'b1;
			end
		end
		end_test("branch");
	endtask

	task automatic mul_test();
		for (int i = 0; i < N_MUL; i++) begin
			case (i)
				0: long_op(1'b0, 1'b1, 32'hffff_fffd, 32'd7);
				1: long_op(1'b0, 1'b0, 32'hffff_fffd, 32'd7);
				2: long_op(1'b0, 1'b1, 32'h8000_0000, 32'h8000_0000);
				default: long_op(1'b0, ~i[0], next_random(), next_random());
			endcase
		end
		end_test("mul");
	endtask

	task automatic div_test();
		logic [31:0] v;
		for (int i = 0; i < N_DIV; i++) begin
			v = next_random();
			case (i)
				0: long_op(1'b1, 1'b0, v, 32'd0);
				1: long_op(1'b1, 1'b1, {1'b1, v[30:0]}, 32'd0);
				2: long_op(1'b1, 1'b1, -32'd100, 32'd7);
				3: long_op(1'b1, 1'b1, 32'd100, -32'd7);
				4: long_op(1'b1, 1'b1, -32'd100, -32'd7);
				default: long_op(1'b1, v[0], next_random(), v >> v[5:1]);
			endcase
		end
		end_test("div");
	endtask

	task automatic move_test();
		for (int i = 0; i < N_MOVE; i++) begin
			next_cycle();
			random_fields();
			hi_wen <= 1'b1;
			hi_src <= cpu_pkg::SRC_RS;
			next_cycle();
			random_fields();
			lo_wen <= 1'b1;
			lo_src <= cpu_pkg::SRC_RS;
			read_hilo();
		end
		// Reset in mid run must clear HI and LO
		next_cycle();
		next_cycle();
		arst_n <= 1'b0;
		repeat (9) next_cycle();
		next_cycle();
		arst_n <= 1'b1;
		read_hilo();
		end_test("move");
	endtask

	initial begin
		while (cycles < LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("simulation timed out after %0d cycles", cycles);
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		seed   = 32'd8675;
		arst_n = 1'b0;
		drive_defaults();
		repeat (10) @(posedge clk);
		arst_n <= 1'b1;
		alu_test();
		shift_test();
		branch_test();
		mul_test();
		div_test();
		move_test();
		$display("checks %0d, errors %0d", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_ex_top -f verilog.f -o tb_ex_top
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/tb_ex_top)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "NO ERRORS"; then
	exit 0
fi
exit 1

//--- source/alu.sv
`timescale 1ns/100ps
module alu (
	input  cpu_pkg::alu_func_t func,
	input  cpu_pkg::word_t     srca,
	input  cpu_pkg::word_t     srcb,
	output cpu_pkg::word_t     result,
	output logic               intovf
);

	cpu_pkg::word_t sum;
	cpu_pkg::word_t diff;

	assign sum  = srca + srcb;
	assign diff = srca - srcb;

	always_comb begin
		case (func)
			cpu_pkg::ADD,
			cpu_pkg::ADDU: result = sum;
			cpu_pkg::SUB,
			cpu_pkg::SUBU: result = diff;
			cpu_pkg::AND:  result = srca & srcb;
			cpu_pkg::OR:   result = srca | srcb;
			cpu_pkg::XOR:  result = srca ^ srcb;
			cpu_pkg::NOR:  result = ~(srca | srcb);
			cpu_pkg::SLT:  result = {31'b0, $signed(srca) < $signed(srcb)};
			cpu_pkg::SLTU: result = {31'b0, srca < srcb};
			// Immediate goes to the upper half
			cpu_pkg::LUI:  result = {srcb[15:0], 16'b0};
			default:       result = '0;
		endcase
	end

	// Signed overflow from operand and result signs
	always_comb begin
		case (func)
			cpu_pkg::ADD: intovf = (srca[31] == srcb[31]) && (sum[31] != srca[31]);
			cpu_pkg::SUB: intovf = (srca[31] != srcb[31]) && (diff[31] != srca[31]);
			default:      intovf = 1'b0;
		endcase
	end

endmodule

//--- source/cpu_pkg.sv
package cpu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [15:0] imm_t;
	typedef logic [4:0]  shamt_t;

	typedef enum logic [3:0] {
		ADD,
		ADDU,
		SUB,
		SUBU,
		AND,
		OR,
		XOR,
		NOR,
		SLT,
		SLTU,
		LUI
	} alu_func_t;

	typedef enum logic [1:0] {
		SLL,
		SRL,
		SRA
	} sft_func_t;

	typedef enum logic [2:0] {
		OUT_ALU,
		OUT_SFT,
		OUT_HI,
		OUT_LO,
		OUT_LINK
	} out_sel_t;

	typedef enum logic [1:0] {
		DST_RT,
		DST_RD,
		DST_RA
	} regdst_t;

	// HI/LO write source
	typedef enum logic [1:0] {
		SRC_MUL,
		SRC_DIV,
		SRC_RS
	} hilo_src_t;

	typedef enum logic [1:0] {
		DIV_IDLE,
		DIV_RUN,
		DIV_DONE
	} div_state_t;

	localparam int MUL_LATENCY = 3;
	localparam int DIV_CYCLES  = 32;
	localparam int DIV_CNT_W   = $clog2(DIV_CYCLES);
	localparam int RA_ADDR     = 31;
	localparam int LINK_OFFSET = 8;

endpackage

//--- source/divider.sv
`timescale 1ns/100ps
module divider (
	input                  clk,
	input                  arst_n,
	input                  start,
	input                  sign,
	input  cpu_pkg::word_t dividend,
	input  cpu_pkg::word_t divisor,
	output logic           done,
	output logic           busy,
	output cpu_pkg::word_t quotient,
	output cpu_pkg::word_t remainder
);

	cpu_pkg::div_state_t             state;
	logic [cpu_pkg::DIV_CNT_W-1:0]   count;
	cpu_pkg::word_t                  quo_q;
	cpu_pkg::word_t                  rem_q;
	cpu_pkg::word_t                  dvsr_q;
	logic                            neg_quo_q;
	logic                            neg_rem_q;
	cpu_pkg::word_t                  dividend_mag;
	cpu_pkg::word_t                  divisor_mag;
	logic [32:0]                     shifted;
	logic [32:0]                     trial;

	assign dividend_mag = (sign && dividend[31]) ? -dividend : dividend;
	assign divisor_mag  = (sign && divisor[31]) ? -divisor : divisor;

	// Bring down the next dividend bit and try to subtract
	assign shifted = {rem_q, quo_q[31]};
	assign trial   = shifted - {1'b0, dvsr_q};

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= cpu_pkg::DIV_IDLE;
			count <= '0;
		end else begin
			case (state)
				cpu_pkg::DIV_IDLE: begin
					if (start) begin
						state <= cpu_pkg::DIV_RUN;
						count <= '0;
					end
				end
				cpu_pkg::DIV_RUN: begin
					count <= count + 1'b1;
					if (count == cpu_pkg::DIV_CNT_W'(cpu_pkg::DIV_CYCLES - 1)) begin
						state <= cpu_pkg::DIV_DONE;
					end
				end
				default: state <= cpu_pkg::DIV_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == cpu_pkg::DIV_IDLE && start) begin
			quo_q     <= dividend_mag;
			rem_q     <= '0;
			dvsr_q    <= divisor_mag;
			neg_quo_q <= sign && (dividend[31] ^ divisor[31]);
			neg_rem_q <= sign && dividend[31];
		end else if (state == cpu_pkg::DIV_RUN) begin
			// Zero divisor always passes, giving all ones
			if (!trial[32]) begin
				rem_q <= trial[31:0];
				quo_q <= {quo_q[30:0], 1'b1};
			end else begin
				rem_q <= shifted[31:0];
				quo_q <= {quo_q[30:0], 1'b0};
			end
		end
	end

	assign done      = (state == cpu_pkg::DIV_DONE);
	assign busy      = (state != cpu_pkg::DIV_IDLE);
	assign quotient  = neg_quo_q ? -quo_q : quo_q;
	assign remainder = neg_rem_q ? -rem_q : rem_q;

	a_div_no_restart: assert property (@(posedge clk) disable iff (!arst_n)
		busy |-> !start)
		else $error("divider started while busy");

endmodule

//--- source/ex.sv
`timescale 1ns/100ps
module ex (
	input                        clk,
	input                        arst_n,
	input                        in_valid,
	input  cpu_pkg::word_t       pc,
	input  cpu_pkg::imm_t        imm,
	input  cpu_pkg::shamt_t      sa,
	input  cpu_pkg::reg_addr_t   rs,
	input  cpu_pkg::reg_addr_t   rt,
	input  cpu_pkg::reg_addr_t   rd,
	input  cpu_pkg::word_t       rsdata,
	input  cpu_pkg::word_t       rtdata,
	input  cpu_pkg::alu_func_t   alu_func,
	input  cpu_pkg::sft_func_t   sft_func,
	input                        imm_sign,
	input                        alu_srcb_rt,
	input                        sft_srca_imm,
	input                        sft_srcb_rs,
	input  cpu_pkg::out_sel_t    out_sel,
	input  cpu_pkg::regdst_t     regdst,
	input                        regwrite,
	input                        intovf_en,
	input                        hi_wen,
	input                        lo_wen,
	input  cpu_pkg::hilo_src_t   hi_src,
	input  cpu_pkg::hilo_src_t   lo_src,
	input                        mul_en,
	input                        mul_sign,
	input                        div_en,
	input                        div_sign,
	input  cpu_pkg::word_t       hi_q,
	input  cpu_pkg::word_t       lo_q,
	output cpu_pkg::word_t       result,
	output cpu_pkg::reg_addr_t   reg_waddr,
	output logic                 regwrite_out,
	output logic                 intovf,
	output logic                 br_equal,
	output logic                 br_gtz,
	output logic                 br_eqz,
	output cpu_pkg::word_t       bta,
	output cpu_pkg::word_t       bpc,
	output logic                 busy,
	output cpu_pkg::word_t       hi_wdata,
	output cpu_pkg::word_t       lo_wdata,
	output logic                 hi_we,
	output logic                 lo_we
);

	cpu_pkg::word_t     imm_ext;
	cpu_pkg::word_t     alu_srcb;
	cpu_pkg::word_t     alu_out;
	logic               alu_ovf;
	cpu_pkg::word_t     sft_value;
	cpu_pkg::shamt_t    sft_amount;
	cpu_pkg::word_t     sft_out;
	logic               mul_start;
	logic               mul_done;
	logic               mul_busy;
	cpu_pkg::word_t     mul_hi;
	cpu_pkg::word_t     mul_lo;
	logic               div_start;
	logic               div_done;
	logic               div_busy;
	cpu_pkg::word_t     div_quo;
	cpu_pkg::word_t     div_rem;
	logic               long_done;
	logic               hi_wen_q;
	logic               lo_wen_q;
	cpu_pkg::hilo_src_t hi_src_q;
	cpu_pkg::hilo_src_t lo_src_q;
	cpu_pkg::hilo_src_t hi_sel;
	cpu_pkg::hilo_src_t lo_sel;

	// Operand selection
	assign imm_ext    = imm_sign ? {{16{imm[15]}}, imm} : {16'b0, imm};
	assign alu_srcb   = alu_srcb_rt ? rtdata : imm_ext;
	assign sft_value  = sft_srca_imm ? imm_ext : rtdata;
	assign sft_amount = sft_srcb_rs ? rsdata[4:0] : sa;

	alu u_alu (
		.func   (alu_func),
		.srca   (rsdata),
		.srcb   (alu_srcb),
		.result (alu_out),
		.intovf (alu_ovf)
	);

	shifter u_shifter (
		.func   (sft_func),
		.value  (sft_value),
		.amount (sft_amount),
		.result (sft_out)
	);

	assign mul_start = in_valid & mul_en;
	assign div_start = in_valid & div_en;

	multiplier u_multiplier (
		.clk    (clk),
		.arst_n (arst_n),
		.start  (mul_start),
		.sign   (mul_sign),
		.srca   (rsdata),
		.srcb   (rtdata),
		.done   (mul_done),
		.busy   (mul_busy),
		.hi     (mul_hi),
		.lo     (mul_lo)
	);

	divider u_divider (
		.clk       (clk),
		.arst_n    (arst_n),
		.start     (div_start),
		.sign      (div_sign),
		.dividend  (rsdata),
		.divisor   (rtdata),
		.done      (div_done),
		.busy      (div_busy),
		.quotient  (div_quo),
		.remainder (div_rem)
	);

	assign busy      = mul_busy | div_busy;
	assign long_done = mul_done | div_done;

	// Branch compare and targets
	assign br_equal = (rsdata == rtdata);
	assign br_eqz   = (rsdata == '0);
	assign br_gtz   = !rsdata[31] && (rsdata != '0);
	assign bta      = pc + 32'd4 + {{14{imm[15]}}, imm, 2'b00};
	assign bpc      = pc + cpu_pkg::word_t'(cpu_pkg::LINK_OFFSET);

	always_comb begin
		case (out_sel)
			cpu_pkg::OUT_SFT:  result = sft_out;
			cpu_pkg::OUT_HI:   result = hi_q;
			cpu_pkg::OUT_LO:   result = lo_q;
			cpu_pkg::OUT_LINK: result = bpc;
			default:           result = alu_out;
		endcase
	end

	always_comb begin
		case (regdst)
			cpu_pkg::DST_RD: reg_waddr = rd;
			cpu_pkg::DST_RA: reg_waddr = cpu_pkg::reg_addr_t'(cpu_pkg::RA_ADDR);
			default:         reg_waddr = rt;
		endcase
	end

	// Overflow cancels the register write
	assign intovf       = intovf_en & alu_ovf;
	assign regwrite_out = regwrite & ~intovf;

	// HI/LO intent for the long operation in flight
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			hi_wen_q <= 1'b0;
			lo_wen_q <= 1'b0;
			hi_src_q <= cpu_pkg::SRC_MUL;
			lo_src_q <= cpu_pkg::SRC_MUL;
		end else if (mul_start || div_start) begin
			hi_wen_q <= hi_wen;
			lo_wen_q <= lo_wen;
			hi_src_q <= hi_src;
			lo_src_q <= lo_src;
		end else if (long_done) begin
			hi_wen_q <= 1'b0;
			lo_wen_q <= 1'b0;
		end
	end

	// Done pulse and a move never share a cycle
	assign hi_sel = long_done ? hi_src_q : hi_src;
	assign lo_sel = long_done ? lo_src_q : lo_src;
	assign hi_we  = long_done ? hi_wen_q : (in_valid && hi_wen && hi_src == cpu_pkg::SRC_RS);
	assign lo_we  = long_done ? lo_wen_q : (in_valid && lo_wen && lo_src == cpu_pkg::SRC_RS);

	always_comb begin
		case (hi_sel)
			cpu_pkg::SRC_MUL: hi_wdata = mul_hi;
			cpu_pkg::SRC_DIV: hi_wdata = div_rem;
			default:          hi_wdata = rsdata;
		endcase
	end

	always_comb begin
		case (lo_sel)
			cpu_pkg::SRC_MUL: lo_wdata = mul_lo;
			cpu_pkg::SRC_DIV: lo_wdata = div_quo;
			default:          lo_wdata = rsdata;
		endcase
	end

	a_no_hilo_read_busy: assert property (@(posedge clk) disable iff (!arst_n)
		(in_valid && busy) |-> !(out_sel inside {cpu_pkg::OUT_HI, cpu_pkg::OUT_LO}))
		else $error("HI/LO read issued while a long operation is busy");

	// Forwarded value for register zero must stay zero
	a_rs_zero: assert property (@(posedge clk) disable iff (!arst_n)
		(in_valid && rs == '0) |-> rsdata == '0)
		else $error("nonzero forwarded data for register zero");

endmodule

//--- source/ex_mem_reg.sv
`timescale 1ns/100ps
module ex_mem_reg (
	input                      clk,
	input                      arst_n,
	input                      valid,
	input                      busy,
	input  cpu_pkg::word_t     pc,
	input  cpu_pkg::word_t     result,
	input  cpu_pkg::reg_addr_t reg_waddr,
	input                      regwrite,
	input                      intovf,
	output logic               mem_valid,
	output cpu_pkg::word_t     mem_pc,
	output cpu_pkg::word_t     mem_result,
	output cpu_pkg::reg_addr_t mem_reg_waddr,
	output logic               mem_regwrite,
	output logic               mem_intovf
);

	logic take;

	// Bubble when nothing valid or a long op holds the stage
	assign take = valid & ~busy;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mem_valid    <= 1'b0;
			mem_regwrite <= 1'b0;
			mem_intovf   <= 1'b0;
		end else begin
			mem_valid    <= take;
			mem_regwrite <= take & regwrite;
			mem_intovf   <= take & intovf;
		end
	end

	always_ff @(posedge clk) begin
		mem_pc        <= pc;
		mem_result    <= result;
		mem_reg_waddr <= reg_waddr;
	end

endmodule

//--- source/ex_top.sv
`timescale 1ns/100ps
module ex_top (
	input                        clk,
	input                        arst_n,
	input                        in_valid,
	input  cpu_pkg::word_t       pc,
	input  cpu_pkg::imm_t        imm,
	input  cpu_pkg::shamt_t      sa,
	input  cpu_pkg::reg_addr_t   rs,
	input  cpu_pkg::reg_addr_t   rt,
	input  cpu_pkg::reg_addr_t   rd,
	input  cpu_pkg::word_t       rsdata,
	input  cpu_pkg::word_t       rtdata,
	input  cpu_pkg::alu_func_t   alu_func,
	input  cpu_pkg::sft_func_t   sft_func,
	input                        imm_sign,
	input                        alu_srcb_rt,
	input                        sft_srca_imm,
	input                        sft_srcb_rs,
	input  cpu_pkg::out_sel_t    out_sel,
	input  cpu_pkg::regdst_t     regdst,
	input                        regwrite,
	input                        intovf_en,
	input                        hi_wen,
	input                        lo_wen,
	input  cpu_pkg::hilo_src_t   hi_src,
	input  cpu_pkg::hilo_src_t   lo_src,
	input                        mul_en,
	input                        mul_sign,
	input                        div_en,
	input                        div_sign,
	output logic                 br_equal,
	output logic                 br_gtz,
	output logic                 br_eqz,
	output cpu_pkg::word_t       bta,
	output cpu_pkg::word_t       bpc,
	output logic                 busy,
	output logic                 mem_valid,
	output cpu_pkg::word_t       mem_pc,
	output cpu_pkg::word_t       mem_result,
	output cpu_pkg::reg_addr_t   mem_reg_waddr,
	output logic                 mem_regwrite,
	output logic                 mem_intovf
);

	cpu_pkg::word_t     ex_result;
	cpu_pkg::reg_addr_t ex_reg_waddr;
	logic               ex_regwrite;
	logic               ex_intovf;
	cpu_pkg::word_t     hi_wdata;
	cpu_pkg::word_t     lo_wdata;
	logic               hi_we;
	logic               lo_we;
	cpu_pkg::word_t     hi_q;
	cpu_pkg::word_t     lo_q;

	ex u_ex (
		.clk          (clk),
		.arst_n       (arst_n),
		.in_valid     (in_valid),
		.pc           (pc),
		.imm          (imm),
		.sa           (sa),
		.rs           (rs),
		.rt           (rt),
		.rd           (rd),
		.rsdata       (rsdata),
		.rtdata       (rtdata),
		.alu_func     (alu_func),
		.sft_func     (sft_func),
		.imm_sign     (imm_sign),
		.alu_srcb_rt  (alu_srcb_rt),
		.sft_srca_imm (sft_srca_imm),
		.sft_srcb_rs  (sft_srcb_rs),
		.out_sel      (out_sel),
		.regdst       (regdst),
		.regwrite     (regwrite),
		.intovf_en    (intovf_en),
		.hi_wen       (hi_wen),
		.lo_wen       (lo_wen),
		.hi_src       (hi_src),
		.lo_src       (lo_src),
		.mul_en       (mul_en),
		.mul_sign     (mul_sign),
		.div_en       (div_en),
		.div_sign     (div_sign),
		.hi_q         (hi_q),
		.lo_q         (lo_q),
		.result       (ex_result),
		.reg_waddr    (ex_reg_waddr),
		.regwrite_out (ex_regwrite),
		.intovf       (ex_intovf),
		.br_equal     (br_equal),
		.br_gtz       (br_gtz),
		.br_eqz       (br_eqz),
		.bta          (bta),
		.bpc          (bpc),
		.busy         (busy),
		.hi_wdata     (hi_wdata),
		.lo_wdata     (lo_wdata),
		.hi_we        (hi_we),
		.lo_we        (lo_we)
	);

	hilo_reg u_hilo_reg (
		.clk      (clk),
		.arst_n   (arst_n),
		.hi_we    (hi_we),
		.lo_we    (lo_we),
		.hi_wdata (hi_wdata),
		.lo_wdata (lo_wdata),
		.hi_q     (hi_q),
		.lo_q     (lo_q)
	);

	ex_mem_reg u_ex_mem_reg (
		.clk           (clk),
		.arst_n        (arst_n),
		.valid         (in_valid),
		.busy          (busy),
		.pc            (pc),
		.result        (ex_result),
		.reg_waddr     (ex_reg_waddr),
		.regwrite      (ex_regwrite),
		.intovf        (ex_intovf),
		.mem_valid     (mem_valid),
		.mem_pc        (mem_pc),
		.mem_result    (mem_result),
		.mem_reg_waddr (mem_reg_waddr),
		.mem_regwrite  (mem_regwrite),
		.mem_intovf    (mem_intovf)
	);

endmodule

//--- source/hilo_reg.sv
`timescale 1ns/100ps
module hilo_reg (
	input                  clk,
	input                  arst_n,
	input                  hi_we,
	input                  lo_we,
	input  cpu_pkg::word_t hi_wdata,
	input  cpu_pkg::word_t lo_wdata,
	output cpu_pkg::word_t hi_q,
	output cpu_pkg::word_t lo_q
);

	// Architectural state cleared on reset
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			hi_q <= '0;
			lo_q <= '0;
		end else begin
			if (hi_we) begin
				hi_q <= hi_wdata;
			end
			if (lo_we) begin
				lo_q <= lo_wdata;
			end
		end
	end

endmodule

//--- source/multiplier.sv
`timescale 1ns/100ps
module multiplier (
	input                  clk,
	input                  arst_n,
	input                  start,
	input                  sign,
	input  cpu_pkg::word_t srca,
	input  cpu_pkg::word_t srcb,
	output logic           done,
	output logic           busy,
	output cpu_pkg::word_t hi,
	output cpu_pkg::word_t lo
);

	localparam int LAT = cpu_pkg::MUL_LATENCY;

	logic [LAT-1:0]     vld_q;
	logic signed [32:0] a_q;
	logic signed [32:0] b_q;
	logic signed [65:0] full;
	logic [63:0]        prod_q [1:LAT-1];

	// Valid bit walks down with the data
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			vld_q <= '0;
		end else begin
			vld_q <= {vld_q[LAT-2:0], start};
		end
	end

	// Extra top bit makes one signed multiply serve both modes
	assign full = 66'(a_q) * 66'(b_q);

	always_ff @(posedge clk) begin
		if (start) begin
			a_q <= {sign & srca[31], srca};
			b_q <= {sign & srcb[31], srcb};
		end
		prod_q[1] <= full[63:0];
		for (int k = 2; k < LAT; k++) begin
			prod_q[k] <= prod_q[k-1];
		end
	end

	assign done = vld_q[LAT-1];
	assign busy = |vld_q;
	assign hi   = prod_q[LAT-1][63:32];
	assign lo   = prod_q[LAT-1][31:0];

	a_mul_latency: assert property (@(posedge clk) disable iff (!arst_n)
		start |-> ##(cpu_pkg::MUL_LATENCY) done)
		else $error("multiplier done not seen at fixed latency");

endmodule

//--- source/shifter.sv
`timescale 1ns/100ps
module shifter (
	input  cpu_pkg::sft_func_t func,
	input  cpu_pkg::word_t     value,
	input  cpu_pkg::shamt_t    amount,
	output cpu_pkg::word_t     result
);

	always_comb begin
		case (func)
			cpu_pkg::SLL: result = value << amount;
			cpu_pkg::SRL: result = value >> amount;
			// Sign bit fills from the left
			cpu_pkg::SRA: result = $signed(value) >>> amount;
			default:      result = '0;
		endcase
	end

endmodule

//--- verilog.f
source/cpu_pkg.sv
source/alu.sv
source/shifter.sv
source/multiplier.sv
source/divider.sv
source/ex.sv
source/hilo_reg.sv
source/ex_mem_reg.sv
source/ex_top.sv
dv/tb_ex_top.sv
